// ==== project.f ====
src/cpuTypesPkg.sv
src/mainDecoder.sv
src/aluDecoder.sv
src/controlUnit.sv
verif/controlUnitChecker.sv
verif/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the decoder testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
        -f project.f --top-module controlUnitTb -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/simv +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
        echo "Simulation passed"
        exit 0
else
        echo "Pass message not found in $LOG"
        exit 1
fi

// ==== src/aluDecoder.sv ====
//~~~~~~~~~~~~~~~~~~~~
// Function-code level of the instruction decoder. Maps the
// R-type function field to an ALU operation and operand select,
// and flags JR and unknown codes for the top level.
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module aluDecoder (
        input  cpuTypesPkg::functT funct,
        output cpuTypesPkg::aluOpT fnAluOp,
        output cpuTypesPkg::selT   fnAluSrc,
        output logic               fnJr,     // Jump-register request
        output logic               fnValid   // Known function code
);
        import cpuTypesPkg::*;

        always_comb begin
                fnAluOp  = aluAdd;
                fnAluSrc = srcRdat2;              // Register operand unless shift
                fnJr     = 1'b0;
                fnValid  = 1'b1;

                case (funct)
                        fnSll: begin
                                fnAluOp  = aluSll;
                                fnAluSrc = srcShamt;
                        end
                        fnSrl: begin
                                fnAluOp  = aluSrl;
                                fnAluSrc = srcShamt;
                        end
                        cpuTypesPkg::fnJr: begin
                                fnJr = 1'b1;      // ALU result unused
                        end
                        fnAdd, fnAddu: begin
                                fnAluOp = aluAdd; // No overflow trap
                        end
                        fnSub, fnSubu: begin
                                fnAluOp = aluSub;
                        end
                        fnAnd: begin
                                fnAluOp = aluAnd;
                        end
                        fnOr: begin
                                fnAluOp = aluOr;
                        end
                        fnXor: begin
                                fnAluOp = aluXor;
                        end
                        fnNor: begin
                                fnAluOp = aluNor;
                        end
                        fnSlt: begin
                                fnAluOp = aluSlt;
                        end
                        fnSltu: begin
                                fnAluOp = aluSltu;
                        end
                        default: begin
                                fnValid = 1'b0;   // Top level turns it into a no-op
                        end
                endcase
        end

endmodule

// ==== src/controlUnit.sv ====
//~~~~~~~~~~~~~~~~~~~~
// Instruction decoder top. Slices the fixed instruction fields
// and merges opcode and function-code decoding into one control set.
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module controlUnit (
        input  cpuTypesPkg::wordT       instr,
        output cpuTypesPkg::regAddrT    rs,
        output cpuTypesPkg::regAddrT    rt,
        output cpuTypesPkg::regAddrT    rd,
        output cpuTypesPkg::shamtT      shamt,
        output cpuTypesPkg::imm16T      imm16,
        output cpuTypesPkg::jumpTargetT jTarget,
        output logic                    regWr,
        output cpuTypesPkg::selT        regDst,
        output logic                    extOp,
        output cpuTypesPkg::selT        aluSrc,
        output cpuTypesPkg::aluOpT      aluOp,
        output cpuTypesPkg::selT        memToReg,
        output logic                    bne,
        output logic                    pcSrc,
        output cpuTypesPkg::selT        jumpSel,
        output logic                    jumpFlush,
        output logic                    halt,
        output logic                    dWEN,
        output logic                    dREN
);
        import cpuTypesPkg::*;

        opcodeT opcode;
        functT  funct;
        logic   rType;
        logic   mainRegWr;                      // Before R-type qualification
        selT    mainAluSrc;
        aluOpT  mainAluOp;
        selT    mainJumpSel;
        logic   mainJumpFlush;
        aluOpT  fnAluOp;
        selT    fnAluSrc;
        logic   fnJr;
        logic   fnValid;

        assign opcode  = instr[31:26];
        assign funct   = instr[5:0];
        assign rs      = instr[25:21];
        assign rt      = instr[20:16];
        assign rd      = instr[15:11];
        assign shamt   = instr[10:6];
        assign imm16   = instr[15:0];
        assign jTarget = instr[25:0];

        mainDecoder mainDec_i (
                .opcode(opcode), .rType(rType), .regWr(mainRegWr), .regDst(regDst),
                .extOp(extOp), .aluSrc(mainAluSrc), .aluOp(mainAluOp),
                .memToReg(memToReg), .bne(bne), .pcSrc(pcSrc), .jumpSel(mainJumpSel),
                .jumpFlush(mainJumpFlush), .halt(halt), .dWEN(dWEN), .dREN(dREN)
        );

        aluDecoder aluDec_i (
                .funct(funct), .fnAluOp(fnAluOp), .fnAluSrc(fnAluSrc),
                .fnJr(fnJr), .fnValid(fnValid)
        );

        // Function field only counts for R-type words
        assign aluOp     = rType ? fnAluOp : mainAluOp;
        assign aluSrc    = rType ? fnAluSrc : mainAluSrc;
        assign regWr     = mainRegWr & ~(rType & (fnJr | ~fnValid)); // JR, bad funct
        assign jumpSel   = (rType & fnJr) ? pcReg : mainJumpSel;       // Target from rs
        assign jumpFlush = mainJumpFlush | (rType & fnJr);

endmodule

// ==== src/cpuTypesPkg.sv ====
//~~~~~~~~~~~~~~~~~~~~
// Shared field types and encodings for the MIPS-style decoder.
// Import into any module that names an opcode, function code,
// ALU operation or datapath select code.
//~~~~~~~~~~~~~~~~~~~~

package cpuTypesPkg;

        // Instruction field types
        typedef logic [31:0] wordT;        // Full instruction word
        typedef logic [5:0]  opcodeT;      // Bits 31:26
        typedef logic [5:0]  functT;       // Bits 5:0 of R-type
        typedef logic [4:0]  regAddrT;     // Register file index
        typedef logic [4:0]  shamtT;       // Shift amount, bits 10:6
        typedef logic [15:0] imm16T;       // Immediate, bits 15:0
        typedef logic [25:0] jumpTargetT;  // J-type target, bits 25:0

        // Datapath control types
        typedef logic [3:0]  aluOpT;       // ALU operation code
        typedef logic [1:0]  selT;         // Two-bit mux select

        // Opcodes
        localparam opcodeT opRtype = 6'h00; // Function field decides
        localparam opcodeT opJ     = 6'h02;
        localparam opcodeT opJal   = 6'h03; // Links into r31
        localparam opcodeT opBeq   = 6'h04;
        localparam opcodeT opBne   = 6'h05;
        localparam opcodeT opAddi  = 6'h08;
        localparam opcodeT opAddiu = 6'h09;
        localparam opcodeT opSlti  = 6'h0A;
        localparam opcodeT opSltiu = 6'h0B;
        localparam opcodeT opAndi  = 6'h0C; // Zero-extended immediate
        localparam opcodeT opOri   = 6'h0D; // Zero-extended immediate
        localparam opcodeT opXori  = 6'h0E; // Zero-extended immediate
        localparam opcodeT opLui   = 6'h0F;
        localparam opcodeT opLw    = 6'h23;
        localparam opcodeT opSw    = 6'h2B;
        localparam opcodeT opHalt  = 6'h3F; // Stops the core

        // R-type function codes
        localparam functT fnSll  = 6'h00;   // Shift by shamt
        localparam functT fnSrl  = 6'h02;   // Shift by shamt
        localparam functT fnJr   = 6'h08;   // Jump to rs
        localparam functT fnAdd  = 6'h20;
        localparam functT fnAddu = 6'h21;
        localparam functT fnSub  = 6'h22;
        localparam functT fnSubu = 6'h23;
        localparam functT fnAnd  = 6'h24;
        localparam functT fnOr   = 6'h25;
        localparam functT fnXor  = 6'h26;
        localparam functT fnNor  = 6'h27;
        localparam functT fnSlt  = 6'h2A;   // Signed compare
        localparam functT fnSltu = 6'h2B;   // Unsigned compare

        // ALU operations
        localparam aluOpT aluSll  = 4'd0;
        localparam aluOpT aluSrl  = 4'd1;
        localparam aluOpT aluAdd  = 4'd2;   // Also address calculation
        localparam aluOpT aluSub  = 4'd3;   // Also branch compare
        localparam aluOpT aluAnd  = 4'd4;
        localparam aluOpT aluOr   = 4'd5;
        localparam aluOpT aluXor  = 4'd6;
        localparam aluOpT aluNor  = 4'd7;
        localparam aluOpT aluSlt  = 4'd8;
        localparam aluOpT aluSltu = 4'd9;

        // Destination register select
        localparam selT dstRt = 2'd0;       // I-type target
        localparam selT dstRd = 2'd1;       // R-type target
        localparam selT dstRa = 2'd2;       // Return address r31

        // ALU second operand select
        localparam selT srcRdat2 = 2'd0;    // Register read port 2
        localparam selT srcShamt = 2'd1;    // Shift amount field
        localparam selT srcImm   = 2'd2;    // Extended immediate

        // Write-back select
        localparam selT wbDmem = 2'd0;      // Load data
        localparam selT wbAlu  = 2'd1;      // ALU result
        localparam selT wbLui  = 2'd2;      // Immediate in upper half
        localparam selT wbPc4  = 2'd3;      // Link address

        // Next-PC select
        localparam selT pcNext   = 2'd0;    // Sequential PC + 4
        localparam selT pcJump   = 2'd1;    // Jump target
        localparam selT pcBranch = 2'd2;    // Branch address
        localparam selT pcReg    = 2'd3;    // Register value for JR

endpackage

// ==== src/mainDecoder.sv ====
//~~~~~~~~~~~~~~~~~~~~
// Opcode level of the instruction decoder. Gives the datapath
// control set for each opcode and flags R-type words, whose
// final ALU controls come from the function-code decoder.
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module mainDecoder (
        input  cpuTypesPkg::opcodeT opcode,
        output logic                rType,     // Function field decides
        output logic                regWr,
        output cpuTypesPkg::selT    regDst,
        output logic                extOp,     // 1 for sign extension
        output cpuTypesPkg::selT    aluSrc,
        output cpuTypesPkg::aluOpT  aluOp,
        output cpuTypesPkg::selT    memToReg,
        output logic                bne,       // Branch on not-zero
        output logic                pcSrc,     // Branch instruction
        output cpuTypesPkg::selT    jumpSel,
        output logic                jumpFlush,
        output logic                halt,
        output logic                dWEN,
        output logic                dREN
);
        import cpuTypesPkg::*;

        always_comb begin
                // Quiet defaults, overridden per opcode
                rType     = 1'b0;
                regWr     = 1'b0;
                regDst    = dstRt;
                extOp     = 1'b0;
                aluSrc    = srcRdat2;
                aluOp     = aluAdd;
                memToReg  = wbDmem;
                bne       = 1'b0;
                pcSrc     = 1'b0;
                jumpSel   = pcNext;
                jumpFlush = 1'b0;
                halt      = 1'b0;
                dWEN      = 1'b0;
                dREN      = 1'b0;

                case (opcode)
                        opRtype: begin
                                rType    = 1'b1;
                                regWr    = 1'b1;   // Cleared at top for JR
                                regDst   = dstRd;
                                memToReg = wbAlu;
                        end
                        opJ: begin
                                jumpSel   = pcJump;
                                jumpFlush = 1'b1;  // Drop fetched word
                        end
                        opJal: begin
                                regWr     = 1'b1;
                                regDst    = dstRa; // Link into r31
                                memToReg  = wbPc4;
                                jumpSel   = pcJump;
                                jumpFlush = 1'b1;
                        end
                        opBeq: begin
                                aluOp   = aluSub;  // Zero flag on equal
                                pcSrc   = 1'b1;
                                jumpSel = pcBranch;
                        end
                        opBne: begin
                                aluOp   = aluSub;
                                bne     = 1'b1;    // Take on not-zero
                                pcSrc   = 1'b1;
                                jumpSel = pcBranch;
                        end
                        opAddi, opAddiu: begin
                                regWr    = 1'b1;
                                extOp    = 1'b1;
                                aluSrc   = srcImm;
                                aluOp    = aluAdd;
                                memToReg = wbAlu;
                        end
                        opSlti: begin
                                regWr    = 1'b1;
                                extOp    = 1'b1;
                                aluSrc   = srcImm;
                                aluOp    = aluSlt;
                                memToReg = wbAlu;
                        end
                        opSltiu: begin
                                regWr    = 1'b1;
                                extOp    = 1'b1;   // Sign-extended, compared unsigned
                                aluSrc   = srcImm;
                                aluOp    = aluSltu;
                                memToReg = wbAlu;
                        end
                        opAndi: begin
                                regWr    = 1'b1;
                                aluSrc   = srcImm; // Zero extension
                                aluOp    = aluAnd;
                                memToReg = wbAlu;
                        end
                        opOri: begin
                                regWr    = 1'b1;
                                aluSrc   = srcImm;
                                aluOp    = aluOr;
                                memToReg = wbAlu;
                        end
                        opXori: begin
                                regWr    = 1'b1;
                                aluSrc   = srcImm;
                                aluOp    = aluXor;
                                memToReg = wbAlu;
                        end
                        opLui: begin
                                regWr    = 1'b1;
                                memToReg = wbLui;  // ALU bypassed
                        end
                        opLw: begin
                                regWr    = 1'b1;
                                extOp    = 1'b1;
                                aluSrc   = srcImm; // Base plus offset
                                aluOp    = aluAdd;
                                memToReg = wbDmem;
                                dREN     = 1'b1;
                        end
                        opSw: begin
                                extOp  = 1'b1;
                                aluSrc = srcImm;
                                aluOp  = aluAdd;
                                dWEN   = 1'b1;     // No register write
                        end
                        opHalt: begin
                                halt = 1'b1;
                        end
                        default: ;                 // Unknown opcode runs as a no-op
                endcase
        end

endmodule

// ==== verif/controlUnitChecker.sv ====
//~~~~~~~~~~~~~~~~~~~~
// Invariants among the decoder's control outputs. Bound into the
// decoder top by the testbench and sampled on the testbench clock.
// Each failure also latches a flag that the testbench polls.
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module controlUnitChecker (
        input logic             CLK,
        input logic             reset,
        input logic             regWr,
        input cpuTypesPkg::selT jumpSel,
        input logic             jumpFlush,
        input logic             pcSrc,
        input logic             halt,
        input logic             dWEN,
        input logic             dREN
);
        import cpuTypesPkg::*;

        logic memBothFail = 1'b0;     // One flag per property
        logic haltFail    = 1'b0;
        logic flushFail   = 1'b0;
        logic branchFail  = 1'b0;
        logic anyViolation;

        assign anyViolation = memBothFail | haltFail | flushFail | branchFail;

        // A word is a load or a store, never both
        memExclusive: assert property (@(posedge CLK) disable iff (reset)
                !(dREN && dWEN))
                else begin
                        memBothFail = 1'b1;
                        $error("dREN and dWEN are high together");
                end

        haltQuiet: assert property (@(posedge CLK) disable iff (reset)
                halt |-> (!regWr && !dWEN && !dREN))  // Core stops with no side effect
                else begin
                        haltFail = 1'b1;
                        $error("halt raised together with a write or memory request");
                end

        flushOnJump: assert property (@(posedge CLK) disable iff (reset)
                jumpFlush |-> (jumpSel == pcJump || jumpSel == pcReg))
                else begin
                        flushFail = 1'b1;
                        $error("jumpFlush high while jumpSel is not a jump source");
                end

        branchSelect: assert property (@(posedge CLK) disable iff (reset)
                pcSrc |-> (jumpSel == pcBranch))    // Branch target only
                else begin
                        branchFail = 1'b1;
                        $error("pcSrc high while jumpSel is not pcBranch");
                end

endmodule

// ==== verif/controlUnitTb.sv ====
//~~~~~~~~~~~~~~~~~~~~
// Testbench for the instruction decoder. Drives directed and
// LFSR-generated words on the falling clock edge and compares every
// output with expected controls built from the decoding rules.
//~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module controlUnitTb;
        import cpuTypesPkg::*;

        localparam int numRandom  = 400;
        localparam int numVectors = 35 + numRandom;     // Directed plus random
        localparam logic [31:0] lfsrSeed = 32'd13535;

        // Valid codes first, then three unassigned ones
        localparam functT dirFuncts [16] = '{fnSll, fnSrl, fnJr, fnAdd, fnAddu, fnSub,
                fnSubu, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu, 6'h01, 6'h15, 6'h3F};
        localparam opcodeT legalOps [16] = '{opRtype, opJ, opJal, opBeq, opBne, opAddi,
                opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui, opLw, opSw, opHalt};

        logic       CLK = 1'b0;
        logic       reset;
        wordT       instr;
        regAddrT    rs, rt, rd;
        shamtT      shamt;
        imm16T      imm16;
        jumpTargetT jTarget;
        logic       regWr, extOp, bne, pcSrc, jumpFlush, halt, dWEN, dREN;
        selT        regDst, aluSrc, memToReg, jumpSel;
        aluOpT      aluOp;

        logic       expRegWr, expExtOp, expBne, expPcSrc, expJumpFlush, expHalt, expDwen, expDren;
        selT        expRegDst, expAluSrc, expMemToReg, expJumpSel;
        aluOpT      expAluOp;
        logic       careWb, careAlu, careExt;           // Field only defined for some words
        logic [31:0] lfsrState;

        controlUnit dut_i (.*);

        bind controlUnit controlUnitChecker chk_i (
                .CLK(controlUnitTb.CLK), .reset(controlUnitTb.reset), .regWr(regWr),
                .jumpSel(jumpSel), .jumpFlush(jumpFlush), .pcSrc(pcSrc), .halt(halt),
                .dWEN(dWEN), .dREN(dREN)
        );

        always #4 CLK = ~CLK;

        function automatic logic [31:0] lfsrStep(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
        endfunction

        function automatic logic [31:0] randomBits(input int n);
                logic [31:0] value;
                value = '0;
                for (int b = 0; b < n; b++) begin
                        lfsrState = lfsrStep(lfsrState);
                        value     = {value[30:0], lfsrState[0]};
                end
                return value;
        endfunction

        // Valid bit on top, ALU operation below
        function automatic logic [4:0] aluForFunct(input functT fn);
                case (fn)
                        fnSll:         return {1'b1, aluSll};
                        fnSrl:         return {1'b1, aluSrl};
                        fnAdd, fnAddu: return {1'b1, aluAdd};
                        fnSub, fnSubu: return {1'b1, aluSub};
                        fnAnd:         return {1'b1, aluAnd};
                        fnOr:          return {1'b1, aluOr};
                        fnXor:         return {1'b1, aluXor};
                        fnNor:         return {1'b1, aluNor};
                        fnSlt:         return {1'b1, aluSlt};
                        fnSltu:        return {1'b1, aluSltu};
                        default:       return 5'd0;     // JR and unknown codes
                endcase
        endfunction

        task automatic computeExpected(input wordT w);
                opcodeT     op;
                functT      fn;
                logic [4:0] fnEntry;
                op      = w[31:26];
                fn      = w[5:0];
                fnEntry = aluForFunct(fn);
                {expRegWr, expBne, expPcSrc, expJumpFlush, expHalt, expDwen, expDren} = 7'd0;
                {careWb, careAlu, careExt} = 3'd0;
                expJumpSel  = pcNext;
                expRegDst   = dstRt;
                expMemToReg = wbAlu;
                expAluOp    = aluAdd;
                expAluSrc   = srcImm;
                expExtOp    = 1'b1;
                case (op)
                        opRtype: begin
                                if (fn == fnJr) begin
                                        expJumpSel   = pcReg;   // Target from rs
                                        expJumpFlush = 1'b1;
                                end else if (fnEntry[4]) begin
                                        {expRegWr, careWb, careAlu} = 3'b111;
                                        expRegDst = dstRd;
                                        expAluOp  = fnEntry[3:0];
                                        expAluSrc = (fn == fnSll || fn == fnSrl) ?
                                                    srcShamt : srcRdat2;
                                end
                        end
                        opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori: begin
                                {expRegWr, careWb, careAlu, careExt} = 4'b1111;
                                expExtOp = (op < opAndi);       // Logical ops zero-extend
                                case (op)
                                        opSlti:  expAluOp = aluSlt;
                                        opSltiu: expAluOp = aluSltu;
                                        opAndi:  expAluOp = aluAnd;
                                        opOri:   expAluOp = aluOr;
                                        opXori:  expAluOp = aluXor;
                                        default: expAluOp = aluAdd;
                                endcase
                        end
                        opLui: begin
                                {expRegWr, careWb} = 2'b11;
                                expMemToReg = wbLui;
                        end
                        opJ: begin
                                expJumpSel   = pcJump;
                                expJumpFlush = 1'b1;
                        end
                        opJal: begin
                                {expRegWr, careWb, expJumpFlush} = 3'b111;
                                expRegDst   = dstRa;            // Link register
                                expMemToReg = wbPc4;
                                expJumpSel  = pcJump;
                        end
                        opBeq, opBne: begin
                                {expPcSrc, careAlu} = 2'b11;
                                expBne     = (op == opBne);
                                expAluOp   = aluSub;
                                expAluSrc  = srcRdat2;          // Two registers compared
                                expJumpSel = pcBranch;
                        end
                        opLw: begin
                                {expRegWr, careWb, careAlu, careExt, expDren} = 5'b11111;
                                expMemToReg = wbDmem;
                        end
                        opSw:    {expDwen, careAlu, careExt} = 3'b111;
                        opHalt:  expHalt = 1'b1;
                        default: ;                              // All enables low
                endcase
        endtask

        task automatic compareField(input string testName, input string field,
                                    input logic [31:0] expected, input logic [31:0] actual);
                assert (expected === actual) else begin
                        $display("MISMATCH %s %s expected %0h actual %0h", testName, field,
                                 expected, actual);
                        $display("TB FAILED");
                        $fatal(1, "Decoder output differs from its expected value");
                end
        endtask

        task automatic applyAndCheck(input wordT w, input string name);
                @(negedge CLK);
                assert (!dut_i.chk_i.anyViolation) else begin
                        $display("Control invariant assertion failed before %s", name);
                        $display("TB FAILED");
                        $fatal(1, "Checker reported a violation");
                end
                instr = w;
                computeExpected(w);
                @(posedge CLK);                                 // Outputs settled
                compareField(name, "rs", 32'(w[25:21]), 32'(rs));
                compareField(name, "rt", 32'(w[20:16]), 32'(rt));
                compareField(name, "rd", 32'(w[15:11]), 32'(rd));
                compareField(name, "shamt", 32'(w[10:6]), 32'(shamt));
                compareField(name, "imm16", 32'(w[15:0]), 32'(imm16));
                compareField(name, "jTarget", 32'(w[25:0]), 32'(jTarget));
                compareField(name, "regWr", 32'(expRegWr), 32'(regWr));
                compareField(name, "bne", 32'(expBne), 32'(bne));
                compareField(name, "pcSrc", 32'(expPcSrc), 32'(pcSrc));
                compareField(name, "jumpSel", 32'(expJumpSel), 32'(jumpSel));
                compareField(name, "jumpFlush", 32'(expJumpFlush), 32'(jumpFlush));
                compareField(name, "halt", 32'(expHalt), 32'(halt));
                compareField(name, "dWEN", 32'(expDwen), 32'(dWEN));
                compareField(name, "dREN", 32'(expDren), 32'(dREN));
                if (careWb) begin
                        compareField(name, "regDst", 32'(expRegDst), 32'(regDst));
                        compareField(name, "memToReg", 32'(expMemToReg), 32'(memToReg));
                end
                if (careAlu) begin
                        compareField(name, "aluOp", 32'(expAluOp), 32'(aluOp));
                        compareField(name, "aluSrc", 32'(expAluSrc), 32'(aluSrc));
                end
                if (careExt)
                        compareField(name, "extOp", 32'(expExtOp), 32'(extOp));
        endtask

        initial begin
                #((numVectors + 20) * 16);                      // Two periods per vector
                $display("Timeout: decoder tests did not finish in time");
                $display("TB FAILED");
                $fatal(1, "Watchdog expired");
        end

        initial begin
                logic [4:0] k;
                wordT       w;
                instr     = '0;
                reset     = 1'b1;
                lfsrState = lfsrSeed;
                repeat (4) @(negedge CLK);
                reset = 1'b0;
                for (k = 5'd0; k < 5'd16; k = k + 5'd1)
                        applyAndCheck({opRtype, 5'd3, 5'd7, 5'd12, 5'd19, dirFuncts[k[3:0]]},
                                      $sformatf("funct %02h", dirFuncts[k[3:0]]));
                for (k = 5'd0; k < 5'd16; k = k + 5'd1)
                        applyAndCheck({legalOps[k[3:0]], 26'h0A5B3C6},
                                      $sformatf("opcode %02h", legalOps[k[3:0]]));
                applyAndCheck({6'h01, 26'h3FFFFFF}, "unknown opcode 01");
                applyAndCheck({6'h10, 26'h3FFFFFF}, "unknown opcode 10");
                applyAndCheck({6'h3E, 26'h3FFFFFF}, "unknown opcode 3e");
                for (int i = 0; i < numRandom; i++) begin
                        w = randomBits(32);
                        if (randomBits(1) == 32'd1)
                                w[31:26] = legalOps[4'(randomBits(4))];   // Legal opcode
                        applyAndCheck(w, $sformatf("random %0d", i));
                end
                @(negedge CLK);
                if (!dut_i.chk_i.anyViolation) begin
                        $display("TB PASSED");
                        $finish;
                end else begin
                        $display("Control invariant assertion failed on the last word");
                        $display("TB FAILED");
                        $fatal(1, "Checker reported a violation");
                end
        end

endmodule
